/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_debug_display
RTL_TOP   ?= debug_display_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= disp_pkg.sv scan_timer.sv digit_scan_fsm.sv seg_decode.sv \
             mmio_regs.sv debug_display_top.sv
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* debug_display_top.sv */
`timescale 1ns/1ns

module debug_display_top #(
  parameter int SCAN_DIV = 500
) (
  input  logic                        clk_50M,
  input  logic                        rst_n,
  input  logic                        bus_wen,
  input  logic                        bus_ren,
  input  logic [disp_pkg::ADDR_W-1:0] bus_addr,
  input  logic [disp_pkg::WORD_W-1:0] bus_wdata,
  input  logic                        debug_sel,
  input  logic [disp_pkg::WORD_W-1:0] debug_word,
  output logic [disp_pkg::WORD_W-1:0] bus_rdata,
  output disp_pkg::an_state_t         an,
  output logic [disp_pkg::SEG_W-1:0]  sev_out,
  output logic [15:0]                 led
);
  import disp_pkg::*;

  logic [WORD_W-1:0]   disp_word;
  logic [3*WORD_W-1:0] key;
  logic [WORD_W-1:0]   shown_word;
  logic                scan_tick;
  logic [3:0]          cur_nibble;

  // register block on the processor bus
  mmio_regs u_regs (
    .clk_50M  (clk_50M),
    .rst_n    (rst_n),
    .bus_wen  (bus_wen),
    .bus_ren  (bus_ren),
    .bus_addr (bus_addr),
    .bus_wdata(bus_wdata),
    .bus_rdata(bus_rdata),
    .disp_word(disp_word),
    .key      (key)
  );

  // low key slice on the leds
  assign led = key[15:0];

  // debug word overrides the display register while selected
  assign shown_word = debug_sel ? debug_word : disp_word;

  scan_timer #(
    .SCAN_DIV(SCAN_DIV)
  ) u_timer (
    .clk_50M  (clk_50M),
    .rst_n    (rst_n),
    .scan_tick(scan_tick)
  );

  digit_scan_fsm u_scan (
    .clk_50M   (clk_50M),
    .rst_n     (rst_n),
    .scan_tick (scan_tick),
    .shown_word(shown_word),
    .an        (an),
    .cur_nibble(cur_nibble)
  );

  seg_decode u_seg (
    .cur_nibble(cur_nibble),
    .sev_out   (sev_out)
  );

endmodule

/* digit_scan_fsm.sv */
`timescale 1ns/1ns

module digit_scan_fsm (
  input  logic                        clk_50M,
  input  logic                        rst_n,
  input  logic                        scan_tick,
  input  logic [disp_pkg::WORD_W-1:0] shown_word,
  output disp_pkg::an_state_t         an,
  output logic [3:0]                  cur_nibble
);
  import disp_pkg::*;

  an_state_t  an_next;
  // index of the digit that becomes active on the next tick
  logic [2:0] digit_next;

  // walk a0..a7 then wrap
  always_comb begin
    case (an)
      a0: begin
        an_next    = a1;
        digit_next = 3'd1;
      end
      a1: begin
        an_next    = a2;
        digit_next = 3'd2;
      end
      a2: begin
        an_next    = a3;
        digit_next = 3'd3;
      end
      a3: begin
        an_next    = a4;
        digit_next = 3'd4;
      end
      a4: begin
        an_next    = a5;
        digit_next = 3'd5;
      end
      a5: begin
        an_next    = a6;
        digit_next = 3'd6;
      end
      a6: begin
        an_next    = a7;
        digit_next = 3'd7;
      end
      default: begin
        // a7 and any stray pattern go back to a0
        an_next    = a0;
        digit_next = 3'd0;
      end
    endcase
  end

  // anode and nibble move on the same edge
  always_ff @(posedge clk_50M) begin
    if (!rst_n) begin
      an         <= a0;
      cur_nibble <= 4'h0;
    end else if (scan_tick) begin
      an         <= an_next;
      cur_nibble <= shown_word[{digit_next, 2'b00} +: 4];
    end
  end

  // exactly one digit lit at any time
  a_an_one_cold : assert property (
    @(posedge clk_50M) disable iff (!rst_n)
    $onehot(~an)
  );

  // no movement between ticks from the scan timer
  a_an_hold : assert property (
    @(posedge clk_50M) disable iff (!rst_n)
    !scan_tick |=> $stable(an)
  );

endmodule

/* disp_pkg.sv */
package disp_pkg;

  // bus and display widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 8;
  localparam int SEG_W  = 7;
  localparam int AN_W   = 8;

  // register map, byte offsets on the mmio bus
  localparam logic [ADDR_W-1:0] ADDR_KEY0 = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_KEY1 = 8'h01;
  localparam logic [ADDR_W-1:0] ADDR_KEY2 = 8'h02;
  localparam logic [ADDR_W-1:0] ADDR_DISP = 8'h10;

  // key value after reset, three 32-bit slices
  // low 16 bits show on the leds, so they come up as e3cf
  localparam logic [3*WORD_W-1:0] KEY_RESET = {
    48'h3cf3cf3cf3cf,
    24'h30c30c,
    12'hbae,
    12'h3cf
  };

  // active-low anode, one digit enabled at a time
  // a0 is the rightmost digit
  typedef enum logic [AN_W-1:0] {
    a0 = 8'b1111_1110,
    a1 = 8'b1111_1101,
    a2 = 8'b1111_1011,
    a3 = 8'b1111_0111,
    a4 = 8'b1110_1111,
    a5 = 8'b1101_1111,
    a6 = 8'b1011_1111,
    a7 = 8'b0111_1111
  } an_state_t;

  // decoded register target
  typedef enum logic [1:0] {
    SEL_DISP = 2'd0,
    SEL_KEY0 = 2'd1,
    SEL_KEY1 = 2'd2,
    SEL_KEY2 = 2'd3
  } reg_sel_t;

endpackage

/* display_checker.sv */
`timescale 1ns/1ns

module display_checker (
  input  logic                        clk_50M,
  input  logic                        rst_n,
  input  logic                        bus_wen,
  input  logic                        bus_ren,
  input  logic [disp_pkg::ADDR_W-1:0] bus_addr,
  input  logic [disp_pkg::WORD_W-1:0] bus_wdata,
  input  logic [disp_pkg::WORD_W-1:0] bus_rdata,
  input  logic [disp_pkg::WORD_W-1:0] exp_rdata,
  input  logic                        debug_sel,
  input  logic [disp_pkg::WORD_W-1:0] debug_word,
  input  logic                        scan_on,
  input  logic [disp_pkg::AN_W-1:0]   an,
  input  logic [disp_pkg::SEG_W-1:0]  sev_out,
  input  logic [15:0]                 led,
  output int                          err_count,
  output int                          rot_count
);
  import disp_pkg::*;

  // register model, moves on the dut's write edge
  logic [WORD_W-1:0]   disp_m;
  logic [3*WORD_W-1:0] key_m;
  logic [WORD_W-1:0]   rd_model;
  logic [WORD_W-1:0]   rd_table;
  logic                rd_pend;
  // scan row seen from the previous edge, word is settled by then
  logic                armed;
  logic [WORD_W-1:0]   rd_held;
  logic [2:0]          idx;
  logic                fresh;
  logic                since_reset;
  logic                armed_d;
  logic [7:0]          seen;
  int                  rot_in_row;
  int                  errs = 0;
  int                  rots = 0;
  logic [SEG_W-1:0]    seg_tab [16];

  assign err_count = errs;
  assign rot_count = rots;

  // common-anode patterns, segment a in bit 6
  initial begin
    seg_tab = '{7'h01, 7'h4f, 7'h12, 7'h06, 7'h4c, 7'h24, 7'h20, 7'h0f,
                7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38};
  end

  // one-cold, digit 0 on bit 0
  function automatic logic [AN_W-1:0] an_pattern(input logic [2:0] k);
    return ~(8'd1 << k);
  endfunction

  function automatic logic [WORD_W-1:0] read_model(input logic [ADDR_W-1:0] a);
    case (a)
      ADDR_KEY0: return key_m[31:0];
      ADDR_KEY1: return key_m[63:32];
      ADDR_KEY2: return key_m[95:64];
      ADDR_DISP: return disp_m;
      default:   return '0;
    endcase
  endfunction

  task automatic value_mismatch(input string name, input logic [WORD_W-1:0] exp_v,
                                input logic [WORD_W-1:0] act_v);
    errs++;
    $display("Fail %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
  endtask

  task automatic scan_failure(input string msg);
    errs++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  always @(posedge clk_50M) begin
    if (!rst_n) begin
      disp_m  <= '0;
      key_m   <= KEY_RESET;
      rd_pend <= 1'b0;
      armed   <= 1'b0;
    end else begin
      armed   <= scan_on;
      rd_pend <= bus_ren;
      // read sees the registers before any write on this edge
      if (bus_ren) begin
        rd_model <= read_model(bus_addr);
        rd_table <= exp_rdata;
      end
      if (bus_wen) begin
        case (bus_addr)
          ADDR_KEY0: key_m[31:0]  <= bus_wdata;
          ADDR_KEY1: key_m[63:32] <= bus_wdata;
          ADDR_KEY2: key_m[95:64] <= bus_wdata;
          ADDR_DISP: disp_m       <= bus_wdata;
          default: ;
        endcase
      end
    end
  end

  // compare on the falling edge, away from the driving edge
  always @(negedge clk_50M) begin
    logic [WORD_W-1:0] shown;
    logic [3:0]        nib;
    if (!rst_n) begin
      rd_held     = '0;
      idx         = 3'd0;
      fresh       = 1'b0;
      since_reset = 1'b1;
      armed_d     = 1'b0;
      seen        = '0;
      rot_in_row  = 0;
    end else begin
      // new read data one cycle after the strobe, held until the next read
      if (rd_pend) begin
        if (bus_rdata !== rd_model)
          value_mismatch("bus_rdata", rd_model, bus_rdata);
        if (bus_rdata !== rd_table)
          value_mismatch("bus_rdata (table)", rd_table, bus_rdata);
        rd_held = rd_model;
      end else if (bus_rdata !== rd_held) begin
        value_mismatch("bus_rdata (held)", rd_held, bus_rdata);
      end
      if (led !== key_m[15:0])
        value_mismatch("led", {16'h0, key_m[15:0]}, {16'h0, led});
      // anode either holds or steps to the next digit
      if (an !== an_pattern(idx)) begin
        if (an === an_pattern(idx + 3'd1)) begin
          idx         = idx + 3'd1;
          since_reset = 1'b0;
          fresh       = armed;
          if (armed) begin
            seen[idx] = 1'b1;
            // all eight digits lit in turn
            if (seen == 8'hff) begin
              rots++;
              rot_in_row++;
              seen = '0;
            end
          end
        end else begin
          value_mismatch("an", {24'h0, an_pattern(idx)}, {24'h0, an});
        end
      end
      if (!armed) begin
        fresh = 1'b0;
        seen  = '0;
      end
      shown = debug_sel ? debug_word : disp_m;
      nib   = shown[4*idx +: 4];
      // nibble is still 0 until the first tick
      if (since_reset && sev_out !== seg_tab[0])
        value_mismatch("sev_out", {25'h0, seg_tab[0]}, {25'h0, sev_out});
      if (fresh && sev_out !== seg_tab[nib])
        value_mismatch("sev_out", {25'h0, seg_tab[nib]}, {25'h0, sev_out});
      if (armed_d && !armed) begin
        if (rot_in_row == 0)
          scan_failure("scan row ended without one full rotation of the anodes");
        rot_in_row = 0;
      end
      armed_d = armed;
    end
  end

endmodule

/* mmio_regs.sv */
`timescale 1ns/1ns

module mmio_regs (
  input  logic                          clk_50M,
  input  logic                          rst_n,
  input  logic                          bus_wen,
  input  logic                          bus_ren,
  input  logic [disp_pkg::ADDR_W-1:0]   bus_addr,
  input  logic [disp_pkg::WORD_W-1:0]   bus_wdata,
  output logic [disp_pkg::WORD_W-1:0]   bus_rdata,
  output logic [disp_pkg::WORD_W-1:0]   disp_word,
  output logic [3*disp_pkg::WORD_W-1:0] key
);
  import disp_pkg::*;

  reg_sel_t          sel;
  logic              hit;
  logic [WORD_W-1:0] rd_val;

  // address decode, anything off the map is a miss
  always_comb begin
    hit = 1'b1;
    case (bus_addr)
      ADDR_DISP: sel = SEL_DISP;
      ADDR_KEY0: sel = SEL_KEY0;
      ADDR_KEY1: sel = SEL_KEY1;
      ADDR_KEY2: sel = SEL_KEY2;
      default: begin
        sel = SEL_DISP;
        hit = 1'b0;
      end
    endcase
  end

  // read mux
  always_comb begin
    case (sel)
      SEL_KEY0: rd_val = key[WORD_W-1:0];
      SEL_KEY1: rd_val = key[2*WORD_W-1:WORD_W];
      SEL_KEY2: rd_val = key[3*WORD_W-1:2*WORD_W];
      default:  rd_val = disp_word;
    endcase
  end

  // register writes, misses dropped
  always_ff @(posedge clk_50M) begin
    if (!rst_n) begin
      disp_word <= '0;
      key       <= KEY_RESET;
    end else if (bus_wen && hit) begin
      case (sel)
        SEL_KEY0: key[WORD_W-1:0]          <= bus_wdata;
        SEL_KEY1: key[2*WORD_W-1:WORD_W]   <= bus_wdata;
        SEL_KEY2: key[3*WORD_W-1:2*WORD_W] <= bus_wdata;
        default:  disp_word                <= bus_wdata;
      endcase
    end
  end

  // read data one cycle after the strobe
  // held until the next read
  always_ff @(posedge clk_50M) begin
    if (!rst_n) begin
      bus_rdata <= '0;
    end else if (bus_ren) begin
      bus_rdata <= hit ? rd_val : '0;
    end
  end

  // bus master never issues both strobes together
  a_no_rw_overlap : assert property (
    @(posedge clk_50M) disable iff (!rst_n)
    !(bus_wen && bus_ren)
  );

endmodule

/* scan_timer.sv */
`timescale 1ns/1ns

module scan_timer #(
  parameter int SCAN_DIV = 500
) (
  input  logic clk_50M,
  input  logic rst_n,
  output logic scan_tick
);

  // counter wide enough for SCAN_DIV-1, never zero bits
  localparam int CNT_W = (SCAN_DIV > 2) ? $clog2(SCAN_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SCAN_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // counts down to zero, reloads and fires one tick
  // first tick lands SCAN_DIV cycles after reset release
  always_ff @(posedge clk_50M) begin
    if (!rst_n) begin
      cnt       <= RELOAD;
      scan_tick <= 1'b0;
    end else begin
      scan_tick <= (cnt == '0);
      if (cnt == '0) begin
        cnt <= RELOAD;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // tick is a strobe, the fsm would skip digits otherwise
  a_tick_single : assert property (
    @(posedge clk_50M) disable iff (!rst_n)
    (SCAN_DIV > 1 && scan_tick) |=> !scan_tick
  );

endmodule

/* seg_decode.sv */
`timescale 1ns/1ns

module seg_decode (
  input  logic [3:0]                 cur_nibble,
  output logic [disp_pkg::SEG_W-1:0] sev_out
);

  // common-anode digits, so a segment is lit when its bit is 0
  // bit 6 is segment a, bit 0 is segment g
  always_comb begin
    case (cur_nibble)
      4'h0: sev_out = 7'b000_0001;
      4'h1: sev_out = 7'b100_1111;
      4'h2: sev_out = 7'b001_0010;
      4'h3: sev_out = 7'b000_0110;
      4'h4: sev_out = 7'b100_1100;
      4'h5: sev_out = 7'b010_0100;
      4'h6: sev_out = 7'b010_0000;
      4'h7: sev_out = 7'b000_1111;
      4'h8: sev_out = 7'b000_0000;
      4'h9: sev_out = 7'b000_0100;
      // letters a..f, b and d in lower case
      4'ha: sev_out = 7'b000_1000;
      4'hb: sev_out = 7'b110_0000;
      4'hc: sev_out = 7'b011_0001;
      4'hd: sev_out = 7'b100_0010;
      4'he: sev_out = 7'b011_0000;
      4'hf: sev_out = 7'b011_1000;
      // blank on an unknown nibble
      default: sev_out = 7'b111_1111;
    endcase
  end

endmodule

/* tb_debug_display.sv */
`timescale 1ns/1ns

module tb_debug_display;
  import disp_pkg::*;

  localparam int SCAN_DIV = 4;
  // two full rotations per scan row
  localparam int SCAN_CYC = 16 * SCAN_DIV;
  localparam int N_ROWS   = 24;
  localparam int LIMIT    = N_ROWS * (SCAN_CYC + 8) + 100;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_SCAN} op_t;

  typedef struct packed {
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic              dsel;
    logic [WORD_W-1:0] dword;
    logic [WORD_W-1:0] exp_val;
    // write takes random data, scan a random debug word, read expects the last random write
    logic              rnd;
  } row_t;

  // key slices after reset: 0cbae3cf, f3cf30c3, 3cf3cf3c
  localparam row_t ROWS [N_ROWS] = '{
    '{OP_RD,   ADDR_KEY0, 32'h0,         1'b0, 32'h0,         32'h0cba_e3cf, 1'b0},
    '{OP_RD,   ADDR_KEY1, 32'h0,         1'b0, 32'h0,         32'hf3cf_30c3, 1'b0},
    '{OP_RD,   ADDR_KEY2, 32'h0,         1'b0, 32'h0,         32'h3cf3_cf3c, 1'b0},
    '{OP_RD,   ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_WR,   ADDR_KEY1, 32'h1234_5678, 1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_RD,   ADDR_KEY1, 32'h0,         1'b0, 32'h0,         32'h1234_5678, 1'b0},
    '{OP_WR,   ADDR_KEY0, 32'ha5a5_c3e1, 1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_RD,   ADDR_KEY0, 32'h0,         1'b0, 32'h0,         32'ha5a5_c3e1, 1'b0},
    '{OP_WR,   ADDR_DISP, 32'h89ab_cdef, 1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_SCAN, ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_SCAN, ADDR_DISP, 32'h0,         1'b1, 32'h0123_4567, 32'h0,         1'b0},
    '{OP_RD,   ADDR_DISP, 32'h0,         1'b1, 32'h0123_4567, 32'h89ab_cdef, 1'b0},
    '{OP_WR,   8'h20,     32'hffff_ffff, 1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_RD,   8'h20,     32'h0,         1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_RD,   ADDR_KEY0, 32'h0,         1'b0, 32'h0,         32'ha5a5_c3e1, 1'b0},
    '{OP_RD,   ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h89ab_cdef, 1'b0},
    '{OP_RD,   ADDR_KEY1, 32'h0,         1'b0, 32'h0,         32'h1234_5678, 1'b0},
    '{OP_RD,   ADDR_KEY2, 32'h0,         1'b0, 32'h0,         32'h3cf3_cf3c, 1'b0},
    '{OP_WR,   ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b1},
    '{OP_SCAN, ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b0},
    '{OP_RD,   ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b1},
    '{OP_SCAN, ADDR_DISP, 32'h0,         1'b1, 32'h0,         32'h0,         1'b1},
    '{OP_WR,   ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b1},
    '{OP_SCAN, ADDR_DISP, 32'h0,         1'b0, 32'h0,         32'h0,         1'b0}
  };

  logic              clk_50M;
  logic              rst_n;
  logic              bus_wen;
  logic              bus_ren;
  logic [ADDR_W-1:0] bus_addr;
  logic [WORD_W-1:0] bus_wdata;
  logic [WORD_W-1:0] bus_rdata;
  logic              debug_sel;
  logic [WORD_W-1:0] debug_word;
  logic [AN_W-1:0]   an;
  logic [SEG_W-1:0]  sev_out;
  logic [15:0]       led;
  // row context for the checker
  logic              scan_on;
  logic [WORD_W-1:0] exp_rdata;
  logic [WORD_W-1:0] rand_disp;
  int                err_count;
  int                rot_count;
  int                cycles = 0;
  row_t              r;

  debug_display_top #(.SCAN_DIV(SCAN_DIV)) uut (
    .clk_50M(clk_50M), .rst_n(rst_n), .bus_wen(bus_wen), .bus_ren(bus_ren),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .debug_sel(debug_sel),
    .debug_word(debug_word), .bus_rdata(bus_rdata), .an(an), .sev_out(sev_out), .led(led)
  );

  display_checker chk (
    .clk_50M(clk_50M), .rst_n(rst_n), .bus_wen(bus_wen), .bus_ren(bus_ren),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .exp_rdata(exp_rdata), .debug_sel(debug_sel), .debug_word(debug_word),
    .scan_on(scan_on), .an(an), .sev_out(sev_out), .led(led),
    .err_count(err_count), .rot_count(rot_count)
  );

  initial begin
    clk_50M = 1'b0;
    forever #10 clk_50M = ~clk_50M;
  end

  // one row, inputs change on rising edges only
  task automatic apply_row(input row_t row);
    @(posedge clk_50M);
    debug_sel  <= row.dsel;
    debug_word <= row.dword;
    bus_addr   <= row.addr;
    case (row.op)
      OP_WR: begin
        bus_wdata <= row.data;
        bus_wen   <= 1'b1;
        @(posedge clk_50M);
        bus_wen   <= 1'b0;
      end
      OP_RD: begin
        exp_rdata <= row.exp_val;
        bus_ren   <= 1'b1;
        @(posedge clk_50M);
        bus_ren   <= 1'b0;
        // checker samples the read data in this cycle
        @(posedge clk_50M);
      end
      default: begin
        scan_on <= 1'b1;
        repeat (SCAN_CYC) @(posedge clk_50M);
        scan_on <= 1'b0;
      end
    endcase
  endtask

  initial begin
    rst_n      = 1'b0;
    bus_wen    = 1'b0;
    bus_ren    = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    debug_sel  = 1'b0;
    debug_word = '0;
    scan_on    = 1'b0;
    exp_rdata  = '0;
    rand_disp  = '0;
    void'($urandom(32'h4599_b814));
    repeat (16) @(posedge clk_50M);
    rst_n <= 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      r = ROWS[i];
      if (r.rnd) begin
        if (r.op == OP_WR) begin
          r.data    = $urandom;
          rand_disp = r.data;
        end else if (r.op == OP_SCAN) begin
          r.dword = $urandom;
        end else begin
          r.exp_val = rand_disp;
        end
      end
      apply_row(r);
    end
    // let the checker see the end of the last scan row
    repeat (4) @(posedge clk_50M);
    $display("errors: %0d, full rotations checked: %0d", err_count, rot_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // run limit sized from the row count
  always @(posedge clk_50M) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

/* vlog.f */
disp_pkg.sv
scan_timer.sv
digit_scan_fsm.sv
seg_decode.sv
mmio_regs.sv
debug_display_top.sv
display_checker.sv
tb_debug_display.sv
